// File: run.sh
#!/bin/sh
# Compile and run the Rasterix testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module RasterixTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VRasterixTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: sim.f
+incdir+source
source/RasterixPkg.sv
source/CommandParser.sv
source/RegisterBank.sv
source/Rasterizer.sv
source/FrameBuffer.sv
source/Rasterix.sv
tests/rasterix_asserts.sv
tests/RasterixTb.sv

// File: source/CommandParser.sv
`timescale 1ns/100ps
`include "rasterix_cfg.svh"

module CommandParser (
    input  logic                   aclk,
    input  logic                   rstN,
    input  logic                   cmdValid,
    output logic                   cmdReady,
    input  logic                   cmdLast,
    input  RasterixPkg::CmdWord    cmdData,
    input  logic                   rasterizerRunning,
    input  logic                   applied,
    output logic                   regStart,
    output logic                   regWrite,
    output RasterixPkg::CmdWord    regData,
    output logic                   startRendering,
    output logic                   apply,
    output logic                   cmdMemset,
    output logic                   cmdCommit,
    output RasterixPkg::PixelColor clearColor
);
    import RasterixPkg::*;

    ParserState state;
    RegIndex    wordsLeft;
    Opcode      opcode;
    logic       accept;

    assign opcode   = Opcode'(cmdData[`CMD_STREAM_WIDTH - 1 -: $bits(Opcode)]);
    assign cmdReady = (state != PsWaitRaster) && (state != PsWaitBuffer);
    assign accept   = cmdValid && cmdReady;

    // Strobes decoded from the word taken this cycle
    assign regStart       = accept && (state == PsIdle) && (opcode == OpTriangle);
    assign regWrite       = accept && (state == PsLoadTriangle);
    assign regData        = cmdData;
    assign startRendering = accept && (state == PsIdle) && (opcode == OpRender);
    assign cmdMemset      = accept && (state == PsLoadClear);
    assign cmdCommit      = accept && (state == PsIdle) && (opcode == OpCommit);
    assign apply          = cmdMemset || cmdCommit;

    always_ff @(posedge aclk) begin
        if (cmdMemset) begin
            clearColor <= PixelColor'(cmdData);
        end
    end

    always_ff @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            state     <= PsIdle;
            wordsLeft <= '0;
        end else begin
            case (state)
                PsIdle: if (accept) begin
                    case (opcode)
                        OpNop:      state <= PsIdle;
                        OpTriangle: begin
                            state     <= PsLoadTriangle;
                            wordsLeft <= RegIndex'(`TRIANGLE_REG_COUNT);
                        end
                        OpClear:    state <= PsLoadClear;
                        OpRender:   state <= PsWaitRaster;
                        OpCommit:   state <= PsWaitBuffer;
                        // Unknown opcode, drop words up to cmdLast
                        default:    if (!cmdLast) state <= PsSkip;
                    endcase
                end
                PsLoadTriangle: if (accept) begin
                    wordsLeft <= wordsLeft - 1'b1;
                    if (wordsLeft == RegIndex'(1)) begin
                        state <= PsIdle;
                    end
                end
                PsLoadClear:  if (accept) state <= PsIdle;
                PsWaitRaster: if (!rasterizerRunning) state <= PsIdle;
                PsWaitBuffer: if (applied) state <= PsIdle;
                PsSkip:       if (accept && cmdLast) state <= PsIdle;
                default:      state <= PsIdle;
            endcase
        end
    end

endmodule

// File: source/FrameBuffer.sv
`timescale 1ns/100ps
`include "rasterix_cfg.svh"

module FrameBuffer (
    input  logic                   aclk,
    input  logic                   rstN,
    input  logic                   fragWrite,
    input  RasterixPkg::FbIndex    fragIndex,
    input  RasterixPkg::PixelColor fragColor,
    input  logic                   apply,
    output logic                   applied,
    input  logic                   cmdMemset,
    input  logic                   cmdCommit,
    input  RasterixPkg::PixelColor clearColor,
    output logic                   fbValid,
    input  logic                   fbReady,
    output logic                   fbLast,
    output RasterixPkg::PixelColor fbData
);
    import RasterixPkg::*;

    PixelColor mem [`FB_SIZE];
    FbState    state;
    FbIndex    addr;
    logic      addrWrapped;
    logic      lastAddr;
    logic      slotFree;
    logic      loadBeat;

    assign applied  = (state == FbIdle);
    assign lastAddr = (addr == FbIndex'(`FB_SIZE - 1));
    // Output register may take a new pixel
    assign slotFree = !fbValid || fbReady;
    assign loadBeat = (state == FbStream) && slotFree && !addrWrapped;

    ////////////////////////////////////////////////////////////
    // Color memory
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (state == FbClear) begin
            mem[addr] <= clearColor;
        end else if (fragWrite) begin
            mem[fragIndex] <= fragColor;
        end
        if (loadBeat) begin
            fbData <= mem[addr];
        end
    end

    ////////////////////////////////////////////////////////////
    // Clear and commit sequencing
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            state       <= FbIdle;
            addr        <= '0;
            addrWrapped <= 1'b0;
            fbValid     <= 1'b0;
            fbLast      <= 1'b0;
        end else begin
            case (state)
                FbIdle: begin
                    addr        <= '0;
                    addrWrapped <= 1'b0;
                    if (apply && cmdMemset) begin
                        state <= FbClear;
                    end else if (apply && cmdCommit) begin
                        state <= FbStream;
                    end
                end
                FbClear: begin
                    addr <= addr + 1'b1;
                    if (lastAddr) begin
                        state <= FbIdle;
                    end
                end
                FbStream: if (slotFree) begin
                    if (!addrWrapped) begin
                        fbValid     <= 1'b1;
                        fbLast      <= lastAddr;
                        addr        <= addr + 1'b1;
                        addrWrapped <= lastAddr;
                    end else begin
                        // Last beat taken
                        fbValid <= 1'b0;
                        fbLast  <= 1'b0;
                        state   <= FbIdle;
                    end
                end
                default: state <= FbIdle;
            endcase
        end
    end

endmodule

// File: source/Rasterix.sv
`timescale 1ns/100ps
`include "rasterix_cfg.svh"

module Rasterix (
    input  logic                   aclk,
    input  logic                   rstN,
    input  logic                   cmdValid,
    output logic                   cmdReady,
    input  logic                   cmdLast,
    input  RasterixPkg::CmdWord    cmdData,
    output logic                   fbValid,
    input  logic                   fbReady,
    output logic                   fbLast,
    output RasterixPkg::PixelColor fbData,
    output logic                   dbgRasterizerRunning
);
    import RasterixPkg::*;

    ////////////////////////////////////////////////////////////
    // Wires
    ////////////////////////////////////////////////////////////
    logic      regStart;
    logic      regWrite;
    CmdWord    regData;
    logic      startRendering;
    logic      rasterizerRunning;
    logic      apply;
    logic      applied;
    logic      cmdMemset;
    logic      cmdCommit;
    PixelColor clearColor;

    // Triangle descriptor
    CmdWord    bbStart;
    CmdWord    bbEnd;
    EdgeValue  w0;
    EdgeValue  w1;
    EdgeValue  w2;
    EdgeValue  w0IncX;
    EdgeValue  w1IncX;
    EdgeValue  w2IncX;
    EdgeValue  w0IncY;
    EdgeValue  w1IncY;
    EdgeValue  w2IncY;
    PixelColor fillColor;

    logic      fragWrite;
    FbIndex    fragIndex;
    PixelColor fragColor;

    assign dbgRasterizerRunning = rasterizerRunning;

    ////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////
    CommandParser commandParser (
        .aclk, .rstN,
        .cmdValid, .cmdReady, .cmdLast, .cmdData,
        .rasterizerRunning, .applied,
        .regStart, .regWrite, .regData,
        .startRendering,
        .apply, .cmdMemset, .cmdCommit, .clearColor
    );

    RegisterBank registerBank (
        .aclk, .rstN,
        .regStart, .regWrite, .regData,
        .bbStart, .bbEnd,
        .w0, .w1, .w2,
        .w0IncX, .w1IncX, .w2IncX,
        .w0IncY, .w1IncY, .w2IncY,
        .fillColor
    );

    Rasterizer rasterizer (
        .aclk, .rstN,
        .startRendering, .rasterizerRunning,
        .bbStart, .bbEnd,
        .w0, .w1, .w2,
        .w0IncX, .w1IncX, .w2IncX,
        .w0IncY, .w1IncY, .w2IncY,
        .fillColor,
        .fragWrite, .fragIndex, .fragColor
    );

    FrameBuffer frameBuffer (
        .aclk, .rstN,
        .fragWrite, .fragIndex, .fragColor,
        .apply, .applied, .cmdMemset, .cmdCommit, .clearColor,
        .fbValid, .fbReady, .fbLast, .fbData
    );

endmodule

// File: source/RasterixPkg.sv
`include "rasterix_cfg.svh"

package RasterixPkg;

    typedef logic [`CMD_STREAM_WIDTH - 1:0]        CmdWord;
    typedef logic [`COLOR_WIDTH - 1:0]             PixelColor;
    typedef logic [$clog2(`X_RESOLUTION) - 1:0]    ScreenCoord;
    typedef logic [$clog2(`FB_SIZE) - 1:0]         FbIndex;
    typedef logic signed [15:0]                    EdgeValue;
    typedef logic [3:0]                            RegIndex;

    typedef enum logic [3:0] {
        OpNop      = 4'd0,
        OpTriangle = 4'd1,
        OpClear    = 4'd2,
        OpRender   = 4'd3,
        OpCommit   = 4'd4
    } Opcode;

    typedef enum logic [2:0] {
        PsIdle,
        PsLoadTriangle,
        PsLoadClear,
        PsWaitRaster,
        PsWaitBuffer,
        PsSkip
    } ParserState;

    typedef enum logic {
        RsIdle,
        RsScan
    } RasterState;

    typedef enum logic [1:0] {
        FbIdle,
        FbClear,
        FbStream
    } FbState;

    // Triangle descriptor slot order
    localparam RegIndex SlotBbStart = 4'd0;
    localparam RegIndex SlotBbEnd   = 4'd1;
    localparam RegIndex SlotW0      = 4'd2;
    localparam RegIndex SlotW1      = 4'd3;
    localparam RegIndex SlotW2      = 4'd4;
    localparam RegIndex SlotW0IncX  = 4'd5;
    localparam RegIndex SlotW1IncX  = 4'd6;
    localparam RegIndex SlotW2IncX  = 4'd7;
    localparam RegIndex SlotW0IncY  = 4'd8;
    localparam RegIndex SlotW1IncY  = 4'd9;
    localparam RegIndex SlotW2IncY  = 4'd10;
    localparam RegIndex SlotColor   = 4'd11;

endpackage

// File: source/Rasterizer.sv
`timescale 1ns/100ps
`include "rasterix_cfg.svh"

module Rasterizer (
    input  logic                   aclk,
    input  logic                   rstN,
    input  logic                   startRendering,
    output logic                   rasterizerRunning,
    input  RasterixPkg::CmdWord    bbStart,
    input  RasterixPkg::CmdWord    bbEnd,
    input  RasterixPkg::EdgeValue  w0,
    input  RasterixPkg::EdgeValue  w1,
    input  RasterixPkg::EdgeValue  w2,
    input  RasterixPkg::EdgeValue  w0IncX,
    input  RasterixPkg::EdgeValue  w1IncX,
    input  RasterixPkg::EdgeValue  w2IncX,
    input  RasterixPkg::EdgeValue  w0IncY,
    input  RasterixPkg::EdgeValue  w1IncY,
    input  RasterixPkg::EdgeValue  w2IncY,
    input  RasterixPkg::PixelColor fillColor,
    output logic                   fragWrite,
    output RasterixPkg::FbIndex    fragIndex,
    output RasterixPkg::PixelColor fragColor
);
    import RasterixPkg::*;

    RasterState state;
    ScreenCoord x;
    ScreenCoord y;
    ScreenCoord startX;
    ScreenCoord startY;
    ScreenCoord endX;
    ScreenCoord endY;
    EdgeValue   e0;
    EdgeValue   e1;
    EdgeValue   e2;
    EdgeValue   row0;
    EdgeValue   row1;
    EdgeValue   row2;
    logic       rowDone;
    logic       boxDone;

    // Box corners, x in the low nibble and y at bit 8
    assign startX  = bbStart[0 +: $bits(ScreenCoord)];
    assign startY  = bbStart[8 +: $bits(ScreenCoord)];
    assign endX    = bbEnd[0 +: $bits(ScreenCoord)];
    assign endY    = bbEnd[8 +: $bits(ScreenCoord)];
    assign rowDone = (x == endX);
    assign boxDone = rowDone && (y == endY);

    assign rasterizerRunning = (state == RsScan);
    assign fragWrite = rasterizerRunning && (e0 >= 0) && (e1 >= 0) && (e2 >= 0);
    assign fragIndex = FbIndex'(y * `X_RESOLUTION + x);
    assign fragColor = fillColor;

    always_ff @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            state <= RsIdle;
        end else if ((state == RsIdle) && startRendering) begin
            state <= RsScan;
        end else if ((state == RsScan) && boxDone) begin
            state <= RsIdle;
        end
    end

    ////////////////////////////////////////////////////////////
    // Position and edge walk
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (state == RsIdle) begin
            if (startRendering) begin
                x    <= startX;
                y    <= startY;
                e0   <= w0;
                e1   <= w1;
                e2   <= w2;
                row0 <= w0;
                row1 <= w1;
                row2 <= w2;
            end
        end else if (rowDone) begin
            // Next row restarts from the row-start values
            x    <= startX;
            y    <= y + 1'b1;
            row0 <= row0 + w0IncY;
            row1 <= row1 + w1IncY;
            row2 <= row2 + w2IncY;
            e0   <= row0 + w0IncY;
            e1   <= row1 + w1IncY;
            e2   <= row2 + w2IncY;
        end else begin
            x  <= x + 1'b1;
            e0 <= e0 + w0IncX;
            e1 <= e1 + w1IncX;
            e2 <= e2 + w2IncX;
        end
    end

endmodule

// File: source/RegisterBank.sv
`timescale 1ns/100ps
`include "rasterix_cfg.svh"

module RegisterBank (
    input  logic                   aclk,
    input  logic                   rstN,
    input  logic                   regStart,
    input  logic                   regWrite,
    input  RasterixPkg::CmdWord    regData,
    output RasterixPkg::CmdWord    bbStart,
    output RasterixPkg::CmdWord    bbEnd,
    output RasterixPkg::EdgeValue  w0,
    output RasterixPkg::EdgeValue  w1,
    output RasterixPkg::EdgeValue  w2,
    output RasterixPkg::EdgeValue  w0IncX,
    output RasterixPkg::EdgeValue  w1IncX,
    output RasterixPkg::EdgeValue  w2IncX,
    output RasterixPkg::EdgeValue  w0IncY,
    output RasterixPkg::EdgeValue  w1IncY,
    output RasterixPkg::EdgeValue  w2IncY,
    output RasterixPkg::PixelColor fillColor
);
    import RasterixPkg::*;

    CmdWord  regFile [`TRIANGLE_REG_COUNT];
    RegIndex writePtr;
    logic    slotWrite;

    // Extra words beyond the last slot are ignored
    assign slotWrite = regWrite && (writePtr < RegIndex'(`TRIANGLE_REG_COUNT));

    always_ff @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            writePtr <= '0;
        end else if (regStart) begin
            writePtr <= '0;
        end else if (slotWrite) begin
            writePtr <= writePtr + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (slotWrite) begin
            regFile[writePtr] <= regData;
        end
    end

    assign bbStart   = regFile[SlotBbStart];
    assign bbEnd     = regFile[SlotBbEnd];
    assign w0        = EdgeValue'(regFile[SlotW0]);
    assign w1        = EdgeValue'(regFile[SlotW1]);
    assign w2        = EdgeValue'(regFile[SlotW2]);
    assign w0IncX    = EdgeValue'(regFile[SlotW0IncX]);
    assign w1IncX    = EdgeValue'(regFile[SlotW1IncX]);
    assign w2IncX    = EdgeValue'(regFile[SlotW2IncX]);
    assign w0IncY    = EdgeValue'(regFile[SlotW0IncY]);
    assign w1IncY    = EdgeValue'(regFile[SlotW1IncY]);
    assign w2IncY    = EdgeValue'(regFile[SlotW2IncY]);
    assign fillColor = PixelColor'(regFile[SlotColor]);

endmodule

// File: source/rasterix_cfg.svh
`ifndef RASTERIX_CFG_SVH
`define RASTERIX_CFG_SVH

// Screen geometry
`define X_RESOLUTION 16
`define Y_RESOLUTION 16
`define FB_SIZE (`X_RESOLUTION * `Y_RESOLUTION)

// Stream word and pixel widths
`define CMD_STREAM_WIDTH 16
`define COLOR_WIDTH 16

// Payload words of one triangle
`define TRIANGLE_REG_COUNT 12

`endif

// File: tests/RasterixTb.sv
`timescale 1ns/100ps
`include "rasterix_cfg.svh"

module RasterixTb;
    import RasterixPkg::*;

    localparam int unsigned Seed = 32'h700b_dc75;
    localparam int TimeoutCycles = 2000;

    logic      aclk;
    logic      rstN;
    logic      cmdValid;
    logic      cmdReady;
    logic      cmdLast;
    CmdWord    cmdData;
    logic      fbValid;
    logic      fbReady;
    logic      fbLast;
    PixelColor fbData;
    logic      dbgRasterizerRunning;

    // Reference frame
    PixelColor frame [`FB_SIZE];
    int        errorCount = 0;

    Rasterix u_Rasterix (
        .aclk, .rstN,
        .cmdValid, .cmdReady, .cmdLast, .cmdData,
        .fbValid, .fbReady, .fbLast, .fbData,
        .dbgRasterizerRunning
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    ////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////
    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            stopWithFailure($sformatf("Mismatch %s: expected 0x%0h, actual 0x%0h",
                                      testName, expected, actual));
        end
    endtask

    task automatic reportTimeout(input string waitName);
        stopWithFailure($sformatf("Timeout while waiting for %s", waitName));
    endtask

    ////////////////////////////////////////////////////////////
    // Command stream
    ////////////////////////////////////////////////////////////
    function automatic CmdWord opWord(input logic [3:0] op);
        return {op, 12'h000};
    endfunction

    // Integer edge function of the edge from a to b, at p
    function automatic int edgeAt(input int ax, input int ay, input int bx, input int by,
                                  input int px, input int py);
        return (bx - ax) * (py - ay) - (by - ay) * (px - ax);
    endfunction

    task automatic sendWord(input CmdWord data, input logic last);
        int gap;
        int count;
        gap = int'($urandom_range(2, 0));
        repeat (gap) begin
            @(posedge aclk);
            #1;
        end
        cmdValid = 1'b1;
        cmdData  = data;
        cmdLast  = last;
        count    = 0;
        while (!cmdReady) begin
            @(posedge aclk);
            #1;
            count++;
            if (count > TimeoutCycles) reportTimeout("cmdReady on a command word");
        end
        @(posedge aclk);
        #1;
        cmdValid = 1'b0;
        cmdLast  = 1'b0;
    endtask

    task automatic waitReady(input string waitName, output logic sawRunning);
        int count;
        count      = 0;
        sawRunning = 1'b0;
        while (!cmdReady) begin
            if (dbgRasterizerRunning) sawRunning = 1'b1;
            @(posedge aclk);
            #1;
            count++;
            if (count > TimeoutCycles) reportTimeout(waitName);
        end
    endtask

    task automatic clearFrame(input PixelColor color);
        sendWord(opWord(OpClear), 1'b0);
        sendWord(CmdWord'(color), 1'b1);
        foreach (frame[i]) frame[i] = color;
        // Buffer clear takes one cycle per pixel
        repeat (`FB_SIZE + 4) begin
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic renderTriangle(input string testName, input PixelColor color);
        int     vx [3];
        int     vy [3];
        int     tmp;
        int     minX;
        int     maxX;
        int     minY;
        int     maxY;
        CmdWord words [`TRIANGLE_REG_COUNT];
        logic   sawRunning;
        for (int k = 0; k < 3; k++) begin
            vx[k] = int'($urandom_range(`X_RESOLUTION - 1, 0));
            vy[k] = int'($urandom_range(`Y_RESOLUTION - 1, 0));
        end
        // Same winding for all three edges
        if (edgeAt(vx[0], vy[0], vx[1], vy[1], vx[2], vy[2]) < 0) begin
            tmp   = vx[1];
            vx[1] = vx[2];
            vx[2] = tmp;
            tmp   = vy[1];
            vy[1] = vy[2];
            vy[2] = tmp;
        end
        minX = vx[0];
        maxX = vx[0];
        minY = vy[0];
        maxY = vy[0];
        for (int k = 1; k < 3; k++) begin
            if (vx[k] < minX) minX = vx[k];
            if (vx[k] > maxX) maxX = vx[k];
            if (vy[k] < minY) minY = vy[k];
            if (vy[k] > maxY) maxY = vy[k];
        end
        words[SlotBbStart] = CmdWord'((minY << 8) | minX);
        words[SlotBbEnd]   = CmdWord'((maxY << 8) | maxX);
        words[SlotW0]      = CmdWord'(edgeAt(vx[1], vy[1], vx[2], vy[2], minX, minY));
        words[SlotW1]      = CmdWord'(edgeAt(vx[2], vy[2], vx[0], vy[0], minX, minY));
        words[SlotW2]      = CmdWord'(edgeAt(vx[0], vy[0], vx[1], vy[1], minX, minY));
        words[SlotW0IncX]  = CmdWord'(vy[1] - vy[2]);
        words[SlotW1IncX]  = CmdWord'(vy[2] - vy[0]);
        words[SlotW2IncX]  = CmdWord'(vy[0] - vy[1]);
        words[SlotW0IncY]  = CmdWord'(vx[2] - vx[1]);
        words[SlotW1IncY]  = CmdWord'(vx[0] - vx[2]);
        words[SlotW2IncY]  = CmdWord'(vx[1] - vx[0]);
        words[SlotColor]   = CmdWord'(color);
        sendWord(opWord(OpTriangle), 1'b0);
        for (int k = 0; k < `TRIANGLE_REG_COUNT; k++) begin
            sendWord(words[k], k == `TRIANGLE_REG_COUNT - 1);
        end
        sendWord(opWord(OpRender), 1'b1);
        waitReady("end of render", sawRunning);
        checkValue({testName, " running seen"}, 32'd1, 32'(sawRunning));
        for (int y = minY; y <= maxY; y++) begin
            for (int x = minX; x <= maxX; x++) begin
                if (edgeAt(vx[1], vy[1], vx[2], vy[2], x, y) >= 0 &&
                    edgeAt(vx[2], vy[2], vx[0], vy[0], x, y) >= 0 &&
                    edgeAt(vx[0], vy[0], vx[1], vy[1], x, y) >= 0) begin
                    frame[y * `X_RESOLUTION + x] = color;
                end
            end
        end
    endtask

    task automatic commitAndCompare(input string testName);
        int   beat;
        int   count;
        logic unused;
        sendWord(opWord(OpCommit), 1'b1);
        beat  = 0;
        count = 0;
        while (beat < `FB_SIZE) begin
            // Roughly 70 percent ready
            fbReady = ($urandom_range(99, 0) < 70);
            if (fbValid && fbReady) begin
                checkValue($sformatf("%s pixel %0d", testName, beat),
                           32'(frame[beat]), 32'(fbData));
                checkValue($sformatf("%s last %0d", testName, beat),
                           32'(beat == `FB_SIZE - 1), 32'(fbLast));
                beat++;
            end
            @(posedge aclk);
            #1;
            count++;
            if (count > TimeoutCycles) reportTimeout("frame buffer beats");
        end
        fbReady = 1'b0;
        waitReady("end of commit", unused);
        checkValue({testName, " fbValid after commit"}, 32'd0, 32'(fbValid));
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(Seed));
        rstN     = 1'b0;
        cmdValid = 1'b0;
        cmdLast  = 1'b0;
        cmdData  = '0;
        fbReady  = 1'b0;
        repeat (5) @(posedge aclk);
        #1;
        rstN = 1'b1;

        checkValue("reset cmdReady", 32'd1, 32'(cmdReady));
        checkValue("reset fbValid", 32'd0, 32'(fbValid));
        checkValue("reset running", 32'd0, 32'(dbgRasterizerRunning));

        clearFrame(PixelColor'($urandom));
        commitAndCompare("clear");

        clearFrame(PixelColor'($urandom));
        renderTriangle("single triangle", PixelColor'($urandom));
        commitAndCompare("single triangle");

        // Overlapping triangles, the later ones on top
        for (int i = 0; i < 5; i++) begin
            renderTriangle($sformatf("overlap %0d", i), PixelColor'($urandom));
        end
        commitAndCompare("overlapping triangles");

        sendWord({4'hA, 12'($urandom)}, 1'b0);
        // Payload that would repaint the frame if it were decoded
        sendWord(opWord(OpClear), 1'b0);
        sendWord(CmdWord'(~frame[0]), 1'b0);
        sendWord(CmdWord'($urandom), 1'b1);
        commitAndCompare("unknown opcode");

        if (errorCount == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stopWithFailure("Errors were recorded during the run");
        end
    end

endmodule

// File: tests/rasterix_asserts.sv
`timescale 1ns/100ps

module RasterixAsserts (
    input logic                   aclk,
    input logic                   rstN,
    input logic                   cmdReady,
    input logic                   fbValid,
    input logic                   fbReady,
    input logic                   fbLast,
    input RasterixPkg::PixelColor fbData,
    input logic                   dbgRasterizerRunning
);

    // Output stream holds while stalled
    fbHold: assert property (@(posedge aclk) disable iff (!rstN)
        fbValid && !fbReady |=> $stable(fbData) && $stable(fbLast))
        else $error("fbData or fbLast changed while fbReady was low");

    fbIdleAfterReset: assert property (@(posedge aclk) $rose(rstN) |-> !fbValid)
        else $error("fbValid high right after reset");

    stallWhileRunning: assert property (@(posedge aclk) disable iff (!rstN)
        dbgRasterizerRunning |-> !cmdReady)
        else $error("cmdReady high while the rasterizer is running");

endmodule

bind Rasterix RasterixAsserts rasterixAsserts (
    .aclk(aclk),
    .rstN(rstN),
    .cmdReady(cmdReady),
    .fbValid(fbValid),
    .fbReady(fbReady),
    .fbLast(fbLast),
    .fbData(fbData),
    .dbgRasterizerRunning(dbgRasterizerRunning)
);
